//--- rtl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // ========================================================================
    // Widths and counts
    // ========================================================================
    localparam int BYTE_W     = 8;
    localparam int I2C_ADDR_W = 7;
    localparam int REG_ADDR_W = 7;
    localparam int CFG_BYTES  = 13;
    // Counter covers byte 0 plus all config bytes
    localparam int CFG_CNT_W  = 4;

    // ========================================================================
    // Sensor configuration image, byte 1 at the MSB end
    // ========================================================================
    typedef struct packed {
        // Byte 1
        logic       crc_en;
        logic [1:0] mag_tempco;
        logic [2:0] conv_avg;
        logic [1:0] i2c_rd;
        // Byte 2
        logic [2:0] thr_hyst;
        logic       lp_ln;
        logic       glitch_filter;
        logic       trigger_mode;
        logic [1:0] operating_mode;
        // Byte 3
        logic [3:0] mag_ch_en;
        logic [3:0] sleep_time;
        // Byte 4
        logic       t_rate;
        logic       intb_pol;
        logic       mag_thr_dir;
        logic       mag_gain_ch;
        logic [1:0] angle_en;
        logic       xy_range;
        logic       z_range;
        // Bytes 5 to 7
        logic [7:0] threshold1;
        logic [7:0] threshold2;
        logic [7:0] threshold3;
        // Byte 8
        logic [1:0] woc_sel;
        logic [1:0] thr_sel;
        logic [1:0] angle_hys;
        logic       angle_offset_en;
        logic       angle_offset_dir;
        // Byte 9, interrupt control
        logic       result_int;
        logic       threshold_int;
        logic       int_state;
        logic [2:0] int_mode;
        logic       int_pol_en;
        logic       mask_int;
        // Bytes 10 to 12
        logic [7:0] gain_x_thr_hi;
        logic [7:0] offset1_y_thr_hi;
        logic [7:0] offset2_z_thr_hi;
        // Byte 13
        logic [6:0] dev_addr;
        logic       dev_addr_update_en;
    } sensor_cfg_t;

    // Default sensor setup
    localparam sensor_cfg_t SENSOR_CFG = '{
        crc_en: 1'b0, mag_tempco: 2'h0, conv_avg: 3'h2, i2c_rd: 2'h0,
        thr_hyst: 3'h0, lp_ln: 1'b1, glitch_filter: 1'b0, trigger_mode: 1'b0,
        operating_mode: 2'h2,
        mag_ch_en: 4'h1, sleep_time: 4'h2,
        t_rate: 1'b1, intb_pol: 1'b1, mag_thr_dir: 1'b0, mag_gain_ch: 1'b0,
        angle_en: 2'h0, xy_range: 1'b0, z_range: 1'b0,
        threshold1: 8'h00, threshold2: 8'h00, threshold3: 8'h00,
        woc_sel: 2'h0, thr_sel: 2'h1, angle_hys: 2'h0,
        angle_offset_en: 1'b0, angle_offset_dir: 1'b0,
        result_int: 1'b1, threshold_int: 1'b1, int_state: 1'b0, int_mode: 3'h3,
        int_pol_en: 1'b0, mask_int: 1'b0,
        gain_x_thr_hi: 8'h00, offset1_y_thr_hi: 8'h00, offset2_z_thr_hi: 8'h00,
        dev_addr: 7'h68, dev_addr_update_en: 1'b0
    };

    // ========================================================================
    // Host request and I2C master command
    // ========================================================================
    typedef struct packed {
        logic [I2C_ADDR_W-1:0] target_addr;
        // 1 selects read
        logic                  rw;
        logic                  conversion;
        logic [REG_ADDR_W-1:0] reg_addr;
    } host_cmd_t;

    typedef struct packed {
        logic [I2C_ADDR_W-1:0] addr;
        logic                  start;
        logic                  read;
        logic                  write;
        logic                  write_multiple;
        logic                  stop;
    } i2c_cmd_t;

    typedef enum logic [1:0] {
        OP_WRITE_CFG,
        OP_WRITE_REG,
        OP_READ_BYTE
    } cmd_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_CMD,
        ST_WR_DATA,
        ST_RD_CMD,
        ST_RD_DATA,
        ST_RD_GET,
        ST_RD_RET,
        ST_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/bridge_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bridge_ctrl import bridge_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    // Captured host request
    input  host_cmd_t req,
    input  logic      req_valid,
    output logic      req_release,
    // Command issue
    output logic      cmd_go,
    output cmd_op_e   cmd_op,
    input  logic      cmd_done,
    // Write data sequencer
    output logic      seq_go,
    output logic      seq_with_cfg,
    input  logic      seq_done,
    // Read return
    output logic      ret_go,
    input  logic      ret_done
);

    ctrl_state_e state;

    // Release is the one ST_DONE cycle
    assign req_release = (state == ST_DONE);

    // ========================================================================
    // Transaction FSM, go pulses registered on state entry
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= ST_IDLE;
            cmd_go       <= 1'b0;
            cmd_op       <= OP_WRITE_CFG;
            seq_go       <= 1'b0;
            seq_with_cfg <= 1'b0;
            ret_go       <= 1'b0;
        end else begin
            // Pulses last one cycle
            cmd_go <= 1'b0;
            seq_go <= 1'b0;
            ret_go <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        cmd_go <= 1'b1;
                        if (req.rw) begin
                            // Read starts with register pointer write
                            state  <= ST_RD_CMD;
                            cmd_op <= OP_WRITE_REG;
                        end else begin
                            state  <= ST_WR_CMD;
                            cmd_op <= OP_WRITE_CFG;
                        end
                    end
                end
                // Write path
                ST_WR_CMD: begin
                    if (cmd_done) begin
                        state        <= ST_WR_DATA;
                        seq_go       <= 1'b1;
                        seq_with_cfg <= 1'b1;
                    end
                end
                ST_WR_DATA: begin
                    if (seq_done) begin
                        state <= ST_DONE;
                    end
                end
                // Read path
                ST_RD_CMD: begin
                    if (cmd_done) begin
                        // Register byte only
                        state        <= ST_RD_DATA;
                        seq_go       <= 1'b1;
                        seq_with_cfg <= 1'b0;
                    end
                end
                ST_RD_DATA: begin
                    if (seq_done) begin
                        // Repeated start for read
                        state  <= ST_RD_GET;
                        cmd_go <= 1'b1;
                        cmd_op <= OP_READ_BYTE;
                    end
                end
                ST_RD_GET: begin
                    if (cmd_done) begin
                        state  <= ST_RD_RET;
                        ret_go <= 1'b1;
                    end
                end
                ST_RD_RET: begin
                    if (ret_done) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/host_cmd_capture.sv
`timescale 1ns/10ps
`default_nettype none

module host_cmd_capture import bridge_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // UART receive stream
    input  logic [BYTE_W-1:0] host_data,
    input  logic              host_valid,
    output logic              host_ready,
    // Request to controller
    output host_cmd_t         req,
    output logic              req_valid,
    input  logic              req_release
);

    logic byte_idx;
    logic hold;
    logic host_fire;

    // Closed while a request is in flight
    assign host_ready = !hold;
    assign host_fire  = host_valid && host_ready;

    // Byte index and hold flag
    always_ff @(posedge clk) begin
        if (!rstn) begin
            byte_idx  <= 1'b0;
            hold      <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            if (host_fire) begin
                byte_idx <= !byte_idx;
                if (byte_idx) begin
                    hold      <= 1'b1;
                    req_valid <= 1'b1;
                end
            end
            if (req_release) begin
                hold <= 1'b0;
            end
        end
    end

    // First byte address and rw, second byte conversion and register
    always_ff @(posedge clk) begin
        if (host_fire && !byte_idx) begin
            req.target_addr <= host_data[BYTE_W-1:1];
            req.rw          <= host_data[0];
        end
        if (host_fire && byte_idx) begin
            req.conversion <= host_data[BYTE_W-1];
            req.reg_addr   <= host_data[REG_ADDR_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/cfg_write_seq.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_write_seq import bridge_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // Control
    input  logic              seq_go,
    input  logic              seq_with_cfg,
    input  host_cmd_t         req,
    // I2C master write stream
    output logic [BYTE_W-1:0] wr_data,
    output logic              wr_valid,
    output logic              wr_last,
    input  logic              wr_ready,
    output logic              seq_done
);

    logic [CFG_CNT_W-1:0]          cnt;
    logic [CFG_BYTES*BYTE_W-1:0]   cfg_bits;
    logic                          at_end;
    logic                          wr_fire;

    assign cfg_bits = SENSOR_CFG;
    assign wr_fire  = wr_valid && wr_ready;

    // ========================================================================
    // Byte select
    // ========================================================================
    // Byte 0 is the register pointer, then config from the MSB end
    always_comb begin
        if (cnt == '0) begin
            wr_data = {req.conversion, req.reg_addr};
        end else begin
            wr_data = cfg_bits[(CFG_BYTES - cnt)*BYTE_W +: BYTE_W];
        end
    end

    // Final byte depends on whether config follows
    assign at_end  = seq_with_cfg ? (cnt == CFG_BYTES) : (cnt == '0);
    assign wr_last = wr_valid && at_end;

    // ========================================================================
    // Stream control
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt      <= '0;
            wr_valid <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            if (seq_go) begin
                cnt      <= '0;
                wr_valid <= 1'b1;
            end else if (wr_fire) begin
                if (at_end) begin
                    wr_valid <= 1'b0;
                    seq_done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2c_cmd_issue.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_cmd_issue import bridge_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    // Request from controller
    input  logic                  cmd_go,
    input  cmd_op_e               cmd_op,
    input  logic [I2C_ADDR_W-1:0] target_addr,
    // I2C master command port
    output i2c_cmd_t              i2c_cmd,
    output logic                  i2c_cmd_valid,
    input  logic                  i2c_cmd_ready,
    output logic                  cmd_done
);

    i2c_cmd_t cmd_next;

    // Opcode to command flags
    always_comb begin
        cmd_next       = '0;
        cmd_next.addr  = target_addr;
        cmd_next.start = 1'b1;
        case (cmd_op)
            OP_WRITE_CFG: begin
                cmd_next.write_multiple = 1'b1;
                cmd_next.stop           = 1'b1;
            end
            // No stop so the read can follow with repeated start
            OP_WRITE_REG: cmd_next.write = 1'b1;
            OP_READ_BYTE: begin
                cmd_next.read = 1'b1;
                cmd_next.stop = 1'b1;
            end
            default: cmd_next.start = 1'b0;
        endcase
    end

    // Command word held while valid
    always_ff @(posedge clk) begin
        if (cmd_go) begin
            i2c_cmd <= cmd_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            i2c_cmd_valid <= 1'b0;
            cmd_done      <= 1'b0;
        end else begin
            cmd_done <= i2c_cmd_valid && i2c_cmd_ready;
            if (cmd_go) begin
                i2c_cmd_valid <= 1'b1;
            end else if (i2c_cmd_ready) begin
                i2c_cmd_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/read_return.sv
`timescale 1ns/10ps
`default_nettype none

module read_return import bridge_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              ret_go,
    // I2C master read stream, rd_last not needed for single byte
    input  logic [BYTE_W-1:0] rd_data,
    input  logic              rd_valid,
    input  logic              rd_last,
    output logic              rd_ready,
    // UART transmit stream
    output logic [BYTE_W-1:0] tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,
    output logic              ret_done
);

    logic rd_fire;

    assign rd_fire = rd_valid && rd_ready;

    // One-entry buffer
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            tx_data <= rd_data;
        end
    end

    // Open for one byte, then present it to the UART
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ready <= 1'b0;
            tx_valid <= 1'b0;
            ret_done <= 1'b0;
        end else begin
            ret_done <= tx_valid && tx_ready;
            if (ret_go) begin
                rd_ready <= 1'b1;
            end else if (rd_fire) begin
                rd_ready <= 1'b0;
            end
            if (rd_fire) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sensor_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_bridge import bridge_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // UART receive stream
    input  logic [BYTE_W-1:0] host_data,
    input  logic              host_valid,
    output logic              host_ready,
    // UART transmit stream
    output logic [BYTE_W-1:0] tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,
    // I2C master command
    output i2c_cmd_t          i2c_cmd,
    output logic              i2c_cmd_valid,
    input  logic              i2c_cmd_ready,
    // I2C master write stream
    output logic [BYTE_W-1:0] wr_data,
    output logic              wr_valid,
    output logic              wr_last,
    input  logic              wr_ready,
    // I2C master read stream
    input  logic [BYTE_W-1:0] rd_data,
    input  logic              rd_valid,
    input  logic              rd_last,
    output logic              rd_ready
);

    // ========================================================================
    // Internal handshakes
    // ========================================================================
    host_cmd_t req;
    logic      req_valid;
    logic      req_release;
    logic      cmd_go;
    cmd_op_e   cmd_op;
    logic      cmd_done;
    logic      seq_go;
    logic      seq_with_cfg;
    logic      seq_done;
    logic      ret_go;
    logic      ret_done;

    bridge_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req),
        .req_valid    (req_valid),
        .req_release  (req_release),
        .cmd_go       (cmd_go),
        .cmd_op       (cmd_op),
        .cmd_done     (cmd_done),
        .seq_go       (seq_go),
        .seq_with_cfg (seq_with_cfg),
        .seq_done     (seq_done),
        .ret_go       (ret_go),
        .ret_done     (ret_done)
    );

    host_cmd_capture u_capture (
        .clk         (clk),
        .rstn        (rstn),
        .host_data   (host_data),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .req         (req),
        .req_valid   (req_valid),
        .req_release (req_release)
    );

    cfg_write_seq u_seq (
        .clk          (clk),
        .rstn         (rstn),
        .seq_go       (seq_go),
        .seq_with_cfg (seq_with_cfg),
        .req          (req),
        .wr_data      (wr_data),
        .wr_valid     (wr_valid),
        .wr_last      (wr_last),
        .wr_ready     (wr_ready),
        .seq_done     (seq_done)
    );

    i2c_cmd_issue u_issue (
        .clk           (clk),
        .rstn          (rstn),
        .cmd_go        (cmd_go),
        .cmd_op        (cmd_op),
        .target_addr   (req.target_addr),
        .i2c_cmd       (i2c_cmd),
        .i2c_cmd_valid (i2c_cmd_valid),
        .i2c_cmd_ready (i2c_cmd_ready),
        .cmd_done      (cmd_done)
    );

    read_return u_ret (
        .clk      (clk),
        .rstn     (rstn),
        .ret_go   (ret_go),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_last  (rd_last),
        .rd_ready (rd_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .ret_done (ret_done)
    );

endmodule

`default_nettype wire

//--- bench/i2c_master_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_model import bridge_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // Command port
    input  i2c_cmd_t          i2c_cmd,
    input  logic              i2c_cmd_valid,
    output logic              i2c_cmd_ready,
    // Write stream
    input  logic [BYTE_W-1:0] wr_data,
    input  logic              wr_valid,
    input  logic              wr_last,
    output logic              wr_ready,
    // Read stream
    output logic [BYTE_W-1:0] rd_data,
    output logic              rd_valid,
    output logic              rd_last,
    input  logic              rd_ready,
    // Last byte returned, for the bench
    output logic [BYTE_W-1:0] ret_byte
);

    integer seed = 96629;
    logic   read_cmd_taken = 1'b0;
    logic   rd_taken = 1'b0;

    initial begin
        i2c_cmd_ready = 1'b0;
        wr_ready      = 1'b0;
        rd_data       = '0;
        rd_valid      = 1'b0;
        rd_last       = 1'b0;
        ret_byte      = '0;
    end

    // Transfers seen at the rising edge
    always @(posedge clk) begin
        read_cmd_taken <= rstn && i2c_cmd_valid && i2c_cmd_ready && i2c_cmd.read;
        rd_taken       <= rstn && rd_valid && rd_ready;
        if (rstn && i2c_cmd_valid && i2c_cmd_ready) begin
            $display("model: command addr 0x%02h flags %05b", i2c_cmd.addr, i2c_cmd[4:0]);
        end
        if (rstn && wr_valid && wr_ready) begin
            $display("model: data 0x%02h last %0b", wr_data, wr_last);
        end
    end

    // Random ready, read byte launched after a read command
    always @(negedge clk) begin
        i2c_cmd_ready = (($random(seed) & 3) != 0);
        wr_ready      = (($random(seed) & 3) != 0);
        if (rd_taken) begin
            rd_valid = 1'b0;
            rd_last  = 1'b0;
        end
        if (read_cmd_taken) begin
            rd_data  = $random(seed);
            rd_valid = 1'b1;
            // Single byte read, so it is also the last
            rd_last  = 1'b1;
            ret_byte = rd_data;
        end
    end

endmodule

`default_nettype wire

//--- bench/sensor_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_bridge_tb import bridge_pkg::*; ;

    localparam int WAIT_LIMIT = 2000;

    logic              clk = 1'b0;
    logic              rstn;
    logic [BYTE_W-1:0] host_data;
    logic              host_valid;
    logic              host_ready;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    i2c_cmd_t          i2c_cmd;
    logic              i2c_cmd_valid;
    logic              i2c_cmd_ready;
    logic [BYTE_W-1:0] wr_data;
    logic              wr_valid;
    logic              wr_last;
    logic              wr_ready;
    logic [BYTE_W-1:0] rd_data;
    logic              rd_valid;
    logic              rd_last;
    logic              rd_ready;
    logic [BYTE_W-1:0] model_byte;

    integer            seed = 96629;
    int                errors = 0;
    int                checks = 0;
    int                host_count = 0;
    logic              timed_out = 1'b0;
    // Transfer logs
    logic [11:0]       cmd_log[$];
    logic [7:0]        wr_log[$];
    logic              last_log[$];
    logic [7:0]        tx_log[$];
    // Stall tracking
    logic              wr_stall_q = 1'b0;
    logic              cmd_stall_q = 1'b0;
    logic              tx_stall_q = 1'b0;
    logic [7:0]        wr_data_q = '0;
    logic              wr_last_q = 1'b0;
    logic [11:0]       cmd_word_q = '0;
    logic [7:0]        tx_data_q = '0;

    sensor_bridge sensor_bridge_inst (
        .clk           (clk),
        .rstn          (rstn),
        .host_data     (host_data),
        .host_valid    (host_valid),
        .host_ready    (host_ready),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .i2c_cmd       (i2c_cmd),
        .i2c_cmd_valid (i2c_cmd_valid),
        .i2c_cmd_ready (i2c_cmd_ready),
        .wr_data       (wr_data),
        .wr_valid      (wr_valid),
        .wr_last       (wr_last),
        .wr_ready      (wr_ready),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .rd_last       (rd_last),
        .rd_ready      (rd_ready)
    );

    i2c_master_model u_model (
        .clk           (clk),
        .rstn          (rstn),
        .i2c_cmd       (i2c_cmd),
        .i2c_cmd_valid (i2c_cmd_valid),
        .i2c_cmd_ready (i2c_cmd_ready),
        .wr_data       (wr_data),
        .wr_valid      (wr_valid),
        .wr_last       (wr_last),
        .wr_ready      (wr_ready),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .rd_last       (rd_last),
        .rd_ready      (rd_ready),
        .ret_byte      (model_byte)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // UART side back-pressure
    always @(negedge clk) begin
        tx_ready = (($random(seed) & 3) != 0);
    end

    // ========================================================================
    // Monitor and stream stability
    // ========================================================================
    always @(posedge clk) begin
        if (rstn) begin
            if (i2c_cmd_valid && i2c_cmd_ready) begin
                cmd_log.push_back(i2c_cmd);
            end
            if (wr_valid && wr_ready) begin
                wr_log.push_back(wr_data);
                last_log.push_back(wr_last);
            end
            if (tx_valid && tx_ready) begin
                tx_log.push_back(tx_data);
            end
            if (host_valid && host_ready) begin
                host_count++;
            end
            // Host side must stay closed while outputs move
            assert (!(host_ready && ((i2c_cmd_valid && i2c_cmd_ready) ||
                    (wr_valid && wr_ready) || (tx_valid && tx_ready)))) else begin
                errors++;
                $display("Output transfer happened while host_ready was high");
            end
            if (wr_stall_q) begin
                assert (wr_valid && wr_data == wr_data_q && wr_last == wr_last_q) else begin
                    errors++;
                    $display("Write stream changed while stalled: 0x%02h/%0b, held 0x%02h/%0b",
                             wr_data, wr_last, wr_data_q, wr_last_q);
                end
            end
            if (cmd_stall_q) begin
                assert (i2c_cmd_valid && i2c_cmd == cmd_word_q) else begin
                    errors++;
                    $display("Command word changed while stalled: 0x%03h, held 0x%03h",
                             i2c_cmd, cmd_word_q);
                end
            end
            if (tx_stall_q) begin
                assert (tx_valid && tx_data == tx_data_q) else begin
                    errors++;
                    $display("UART byte changed while stalled: 0x%02h, held 0x%02h",
                             tx_data, tx_data_q);
                end
            end
        end
        wr_stall_q  <= rstn && wr_valid && !wr_ready;
        cmd_stall_q <= rstn && i2c_cmd_valid && !i2c_cmd_ready;
        tx_stall_q  <= rstn && tx_valid && !tx_ready;
        wr_data_q   <= wr_data;
        wr_last_q   <= wr_last;
        cmd_word_q  <= i2c_cmd;
        tx_data_q   <= tx_data;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // Remaining steps are skipped once a wait has run out
    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_host_byte(input logic [7:0] b);
        int waited;
        waited     = 0;
        host_data  = b;
        host_valid = 1'b1;
        while (!host_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!host_ready) begin
            report_timeout("host byte acceptance");
        end else begin
            @(negedge clk);
        end
        host_valid = 1'b0;
    endtask

    // Two host bytes, then a stray byte offered until the bridge reopens
    task automatic issue_request(input logic [6:0] addr, input logic rw,
                                 input logic [7:0] reg_byte);
        int waited;
        waited = 0;
        cmd_log.delete();
        wr_log.delete();
        last_log.delete();
        tx_log.delete();
        host_count = 0;
        send_host_byte({addr, rw});
        if (!timed_out) begin
            send_host_byte(reg_byte);
        end
        if (!timed_out) begin
            host_data  = 8'hA5;
            host_valid = 1'b1;
            expect_equal("host_ready after request", 0, host_ready);
            while (!host_ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            host_valid = 1'b0;
            if (!host_ready) begin
                report_timeout("host_ready return");
            end else begin
                expect_equal("host bytes taken", 2, host_count);
            end
        end
    endtask

    task automatic check_reset_state();
        expect_equal("reset host_ready", 1, host_ready);
        expect_equal("reset i2c_cmd_valid", 0, i2c_cmd_valid);
        expect_equal("reset wr_valid", 0, wr_valid);
        expect_equal("reset rd_ready", 0, rd_ready);
        expect_equal("reset tx_valid", 0, tx_valid);
    endtask

    task automatic run_write(input logic [6:0] addr, input logic [7:0] reg_byte);
        i2c_cmd_t                    exp_cmd;
        logic [CFG_BYTES*BYTE_W-1:0] img;
        int                          i;
        exp_cmd                = '0;
        exp_cmd.addr           = addr;
        exp_cmd.start          = 1'b1;
        exp_cmd.write_multiple = 1'b1;
        exp_cmd.stop           = 1'b1;
        img                    = SENSOR_CFG;
        issue_request(addr, 1'b0, reg_byte);
        if (!timed_out) begin
            expect_equal("write command count", 1, cmd_log.size());
            if (cmd_log.size() > 0) begin
                expect_equal("write command word", exp_cmd, cmd_log[0]);
            end
            expect_equal("write byte count", CFG_BYTES + 1, wr_log.size());
            expect_equal("write tx count", 0, tx_log.size());
            for (i = 0; i < wr_log.size() && i <= CFG_BYTES; i++) begin
                if (i == 0) begin
                    expect_equal("write register byte", reg_byte, wr_log[0]);
                end else begin
                    // Configuration bytes leave from the top of the image
                    expect_equal($sformatf("write cfg byte %0d", i), img[103:96], wr_log[i]);
                    img = img << BYTE_W;
                end
                expect_equal($sformatf("write last %0d", i), (i == CFG_BYTES), last_log[i]);
            end
        end
    endtask

    task automatic run_read(input logic [6:0] addr, input logic [7:0] reg_byte);
        i2c_cmd_t ptr_cmd;
        i2c_cmd_t get_cmd;
        ptr_cmd       = '0;
        ptr_cmd.addr  = addr;
        ptr_cmd.start = 1'b1;
        ptr_cmd.write = 1'b1;
        get_cmd       = '0;
        get_cmd.addr  = addr;
        get_cmd.start = 1'b1;
        get_cmd.read  = 1'b1;
        get_cmd.stop  = 1'b1;
        issue_request(addr, 1'b1, reg_byte);
        if (!timed_out) begin
            expect_equal("read command count", 2, cmd_log.size());
            if (cmd_log.size() == 2) begin
                expect_equal("read pointer command", ptr_cmd, cmd_log[0]);
                expect_equal("read fetch command", get_cmd, cmd_log[1]);
            end
            expect_equal("read byte count", 1, wr_log.size());
            if (wr_log.size() == 1) begin
                expect_equal("read register byte", reg_byte, wr_log[0]);
                expect_equal("read register last", 1, last_log[0]);
            end
            expect_equal("read tx count", 1, tx_log.size());
            if (tx_log.size() == 1) begin
                expect_equal("read tx byte", model_byte, tx_log[0]);
            end
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        rstn       = 1'b0;
        host_data  = '0;
        host_valid = 1'b0;
        tx_ready   = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_reset_state();
        run_write(7'h35, 8'h8A);
        if (!timed_out) begin
            run_read(7'h35, 8'h03);
        end
        // Back to back after the read
        if (!timed_out) begin
            run_write(7'h22, 8'h10);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- sensor_bridge.f
rtl/bridge_pkg.sv
rtl/bridge_ctrl.sv
rtl/host_cmd_capture.sv
rtl/cfg_write_seq.sv
rtl/i2c_cmd_issue.sv
rtl/read_return.sv
rtl/sensor_bridge.sv
bench/i2c_master_model.sv
bench/sensor_bridge_tb.sv
